// File: hazardMonitor.sv
`timescale 1ns/1ps
`default_nettype none

module hazardMonitor (
    input  logic        clk,
    input  logic        checkEn,
    input  logic [31:0] instrD,
    input  logic        busy,
    input  logic        start,
    input  logic        expStall,
    input  logic        expMduClr,
    input  logic        pcWrite,
    input  logic        ifIdEn,
    input  logic        idExClr,
    input  logic        mduClr,
    output int          checkCount,
    output int          errorCount
);

    int checks = 0;
    int errors = 0;

    assign checkCount = checks;
    assign errorCount = errors;

    task automatic compare(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors = errors + 1;
            $display("FAILED %0t: %s is %b, expected %b (instrD %h busy %b start %b)",
                     $time, name, got, exp, instrD, busy, start);
        end
    endtask

    // Outputs settle after the rising edge, compare mid-cycle
    always @(negedge clk) begin
        if (checkEn) begin
            checks = checks + 1;
            compare("idExClr", idExClr, expStall);
            compare("pcWrite", pcWrite, ~expStall);
            compare("ifIdEn", ifIdEn, ~expStall);
            compare("mduClr", mduClr, expMduClr);
        end
    end

endmodule

`default_nettype wire

// File: hazardPkg.sv
`default_nettype none

package hazardPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction word fields
    ////////////////////////////////////////////////////////////////////////////

    localparam int opMsb    = 31;
    localparam int opLsb    = 26;
    localparam int rsMsb    = 25;
    localparam int rsLsb    = 21;
    localparam int rtMsb    = 20;
    localparam int rtLsb    = 16;
    localparam int rdMsb    = 15;
    localparam int rdLsb    = 11;
    localparam int functMsb = 5;
    localparam int functLsb = 0;

    localparam int regNumW = 5;
    localparam int timeW   = 2;

    ////////////////////////////////////////////////////////////////////////////
    // Latencies
    ////////////////////////////////////////////////////////////////////////////

    // Tnew seen from the execute stage
    localparam logic [timeW-1:0] tnewLink = 2'd0;
    localparam logic [timeW-1:0] tnewAlu  = 2'd1;
    localparam logic [timeW-1:0] tnewLoad = 2'd2;

    // Tuse counted from decode
    localparam logic [timeW-1:0] tuseDecode = 2'd0;
    localparam logic [timeW-1:0] tuseExec   = 2'd1;
    localparam logic [timeW-1:0] tuseMem    = 2'd2;

    localparam logic [regNumW-1:0] linkReg = 5'd31;

    ////////////////////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [5:0] {
        opRType = 6'h00,
        opJ     = 6'h02,
        opJal   = 6'h03,
        opBeq   = 6'h04,
        opBne   = 6'h05,
        opAddi  = 6'h08,
        opAndi  = 6'h0c,
        opOri   = 6'h0d,
        opLui   = 6'h0f,
        opLb    = 6'h20,
        opLh    = 6'h21,
        opLw    = 6'h23,
        opSb    = 6'h28,
        opSh    = 6'h29,
        opSw    = 6'h2b
    } opcodeT;

    typedef enum logic [5:0] {
        functJr      = 6'h08,
        functMfhi    = 6'h10,
        functMthi    = 6'h11,
        functMflo    = 6'h12,
        functMtlo    = 6'h13,
        functMult    = 6'h18,
        functMultu   = 6'h19,
        functDiv     = 6'h1a,
        functDivu    = 6'h1b,
        functFastdiv = 6'h1c,   // local extension, issued like div
        functAdd     = 6'h20,
        functSub     = 6'h22,
        functAnd     = 6'h24,
        functOr      = 6'h25,
        functSlt     = 6'h2a,
        functSltu    = 6'h2b
    } functT;

endpackage

`default_nettype wire

// File: hazardTb.sv
`timescale 1ns/1ps
`default_nettype none

module hazardTb import hazardPkg::*; ();

    localparam int clkPeriod = 100;

    logic        clk;
    logic        rstN;
    logic [31:0] instrD;
    logic        busy;
    logic        start;
    logic        pcWrite;
    logic        ifIdEn;
    logic        idExClr;
    logic        mduClr;
    logic        expStall;
    logic        expMduClr;
    logic        checkEn;
    int          checkCount;
    int          errorCount;
    int          assertFails;

    // One entry per cycle, rows repeat while decode is held
    logic [31:0] instrTab[$];
    logic        busyTab[$];
    logic        startTab[$];
    logic        stallTab[$];
    logic        mduClrTab[$];

    hazardTop u_hazardTop (
        .clk     (clk),
        .rstN    (rstN),
        .instrD  (instrD),
        .busy    (busy),
        .start   (start),
        .pcWrite (pcWrite),
        .ifIdEn  (ifIdEn),
        .idExClr (idExClr),
        .mduClr  (mduClr)
    );

    hazardMonitor u_hazardMonitor (
        .clk        (clk),
        .checkEn    (checkEn),
        .instrD     (instrD),
        .busy       (busy),
        .start      (start),
        .expStall   (expStall),
        .expMduClr  (expMduClr),
        .pcWrite    (pcWrite),
        .ifIdEn     (ifIdEn),
        .idExClr    (idExClr),
        .mduClr     (mduClr),
        .checkCount (checkCount),
        .errorCount (errorCount)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Instruction encoding
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] encR(input int rs, input int rt, input int rd, input functT f);
        return {opRType, 5'(rs), 5'(rt), 5'(rd), 5'd0, f};
    endfunction

    function automatic logic [31:0] encI(input opcodeT op, input int rs, input int rt, input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic logic [31:0] encJ(input opcodeT op, input int target);
        return {op, 26'(target)};
    endfunction

    task automatic addRow(input logic [31:0] instr, input logic b, input logic s,
                          input logic stallExp, input logic mduExp);
        instrTab.push_back(instr);
        busyTab.push_back(b);
        startTab.push_back(s);
        stallTab.push_back(stallExp);
        mduClrTab.push_back(mduExp);
    endtask

    //           instruction                         busy  start stall mduClr
    task automatic loadTable();
        addRow(encI(opAddi, 1, 1, 5),               0, 0, 0, 0);
        addRow(encR(4, 5, 3, functAdd),             0, 0, 0, 0);
        addRow(encI(opSw, 7, 6, 0),                 0, 0, 0, 0);
        // Load then ALU reader
        addRow(encI(opLw, 9, 8, 0),                 0, 0, 0, 0);
        addRow(encR(8, 11, 10, functAdd),           0, 0, 1, 0);
        addRow(encR(8, 11, 10, functAdd),           0, 0, 0, 0);
        // Load then branch, two bubbles
        addRow(encI(opLw, 0, 12, 0),                0, 0, 0, 0);
        addRow(encI(opBeq, 12, 13, 4),              0, 0, 1, 0);
        addRow(encI(opBeq, 12, 13, 4),              0, 0, 1, 0);
        addRow(encI(opBeq, 12, 13, 4),              0, 0, 0, 0);
        // Load then store data
        addRow(encI(opLw, 0, 14, 4),                0, 0, 0, 0);
        addRow(encI(opSw, 1, 14, 8),                0, 0, 0, 0);
        // ALU then branch and jr
        addRow(encR(1, 2, 15, functAdd),            0, 0, 0, 0);
        addRow(encI(opBeq, 15, 0, 2),               0, 0, 1, 0);
        addRow(encI(opBeq, 15, 0, 2),               0, 0, 0, 0);
        addRow(encI(opOri, 0, 16, 1),               0, 0, 0, 0);
        addRow(encR(16, 0, 0, functJr),             0, 0, 1, 0);
        addRow(encR(16, 0, 0, functJr),             0, 0, 0, 0);
        // ALU then add and sw
        addRow(encI(opAddi, 0, 17, 3),              0, 0, 0, 0);
        addRow(encR(17, 17, 18, functAdd),          0, 0, 0, 0);
        addRow(encI(opSw, 18, 18, 0),               0, 0, 0, 0);
        // r0 and readers of nothing
        addRow(encI(opLw, 1, 0, 0),                 0, 0, 0, 0);
        addRow(encI(opBeq, 0, 0, 1),                0, 0, 0, 0);
        addRow(encI(opLw, 0, 19, 0),                0, 0, 0, 0);
        addRow(encI(opLui, 19, 20, 'h1234),         0, 0, 0, 0);
        addRow(encI(opLw, 0, 24, 0),                0, 0, 0, 0);
        addRow(encJ(opJ, (24 << 21) | (24 << 16) | 'h40), 0, 0, 0, 0);
        addRow(encI(opLw, 0, 25, 0),                0, 0, 0, 0);
        addRow(encJ(opJal, (25 << 21) | (25 << 16) | 'h80), 0, 0, 0, 0);
        addRow(encR(31, 0, 0, functJr),             0, 0, 0, 0);
        // Multiply/divide unit occupied
        addRow(encR(1, 2, 0, functMult),            1, 0, 0, 1);
        addRow(encR(3, 4, 0, functMultu),           0, 1, 0, 1);
        addRow(encR(5, 6, 0, functDiv),             1, 1, 0, 1);
        addRow(encR(7, 9, 0, functDivu),            1, 0, 0, 1);
        addRow(encR(1, 3, 0, functFastdiv),         0, 1, 0, 1);
        addRow(encR(0, 0, 21, functMfhi),           1, 0, 1, 0);
        addRow(encR(0, 0, 21, functMfhi),           0, 0, 0, 0);
        addRow(encR(0, 0, 22, functMflo),           0, 1, 1, 0);
        addRow(encR(0, 0, 22, functMflo),           0, 0, 0, 0);
        addRow(encR(22, 0, 0, functMthi),           1, 0, 1, 0);
        addRow(encR(22, 0, 0, functMthi),           0, 0, 0, 0);
        addRow(encR(1, 0, 0, functMtlo),            0, 1, 1, 0);
        addRow(encR(1, 0, 0, functMtlo),            0, 0, 0, 0);
        // Unit idle
        addRow(encR(1, 2, 0, functMult),            0, 0, 0, 0);
        addRow(encR(3, 4, 0, functDiv),             0, 0, 0, 0);
        addRow(encR(0, 0, 23, functMfhi),           0, 0, 0, 0);
        addRow(encI(opBne, 23, 0, 3),               0, 0, 1, 0);
        addRow(encI(opBne, 23, 0, 3),               0, 0, 0, 0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Clock, stimulus and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        rstN      = 1'b0;
        // Load into r1 sits in decode while reset keeps the slots empty
        instrD    = encI(opLw, 0, 1, 0);
        busy      = 1'b0;
        start     = 1'b0;
        expStall  = 1'b0;
        expMduClr = 1'b0;
        checkEn   = 1'b0;
        loadTable();

        fork
            begin
                #((instrTab.size() + 5 + 20) * clkPeriod);
                $display("Timeout: the table did not finish in time");
                $display("Regression failed");
                $finish;
            end
        join_none

        repeat (5) @(posedge clk);
        for (int i = 0; i < instrTab.size(); i++) begin
            rstN      <= 1'b1;
            checkEn   <= 1'b1;
            instrD    <= instrTab[i];
            busy      <= busyTab[i];
            start     <= startTab[i];
            expStall  <= stallTab[i];
            expMduClr <= mduClrTab[i];
            @(posedge clk);
        end
        checkEn <= 1'b0;
        @(negedge clk);

        assertFails = u_hazardTop.u_hazardTopChecker.failCount;
        $display("Checked %0d cycles, %0d errors, %0d assertion failures",
                 checkCount, errorCount, assertFails);
        if (errorCount == 0 && assertFails == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hazardTop.sv
`timescale 1ns/1ps
`default_nettype none

module hazardTop import hazardPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic [31:0] instrD,
    input  logic        busy,
    input  logic        start,
    output logic        pcWrite,
    output logic        ifIdEn,
    output logic        idExClr,
    output logic        mduClr
);

    logic [regNumW-1:0] useRs;
    logic [regNumW-1:0] useRt;
    logic [timeW-1:0]   tuseRs;
    logic [timeW-1:0]   tuseRt;
    logic               mdAccess;
    logic               mdStart;
    logic [regNumW-1:0] newRegE;
    logic [timeW-1:0]   tnewE;
    logic [regNumW-1:0] newRegM;
    logic [timeW-1:0]   tnewM;
    logic               stall;

    useDecoder u_useDecoder (
        .instrD   (instrD),
        .useRs    (useRs),
        .useRt    (useRt),
        .tuseRs   (tuseRs),
        .tuseRt   (tuseRt),
        .mdAccess (mdAccess),
        .mdStart  (mdStart)
    );

    writerTracker u_writerTracker (
        .clk     (clk),
        .rstN    (rstN),
        .instrD  (instrD),
        .stall   (stall),
        .newRegE (newRegE),
        .tnewE   (tnewE),
        .newRegM (newRegM),
        .tnewM   (tnewM)
    );

    stallController u_stallController (
        .useRs    (useRs),
        .useRt    (useRt),
        .tuseRs   (tuseRs),
        .tuseRt   (tuseRt),
        .mdAccess (mdAccess),
        .mdStart  (mdStart),
        .newRegE  (newRegE),
        .tnewE    (tnewE),
        .newRegM  (newRegM),
        .tnewM    (tnewM),
        .busy     (busy),
        .start    (start),
        .stall    (stall),
        .pcWrite  (pcWrite),
        .ifIdEn   (ifIdEn),
        .idExClr  (idExClr),
        .mduClr   (mduClr)
    );

endmodule

`default_nettype wire

// File: hazardTop_checker.sv
`timescale 1ns/1ps
`default_nettype none

module hazardTop_checker (
    input logic clk,
    input logic rstN,
    input logic busy,
    input logic start,
    input logic pcWrite,
    input logic ifIdEn,
    input logic idExClr,
    input logic mduClr
);

    int failCount = 0;

    clrInverse: assert property (@(posedge clk) disable iff (!rstN) idExClr == !pcWrite)
        else begin
            failCount = failCount + 1;
            $error("idExClr is not the inverse of pcWrite");
        end

    enablesMatch: assert property (@(posedge clk) disable iff (!rstN) pcWrite == ifIdEn)
        else begin
            failCount = failCount + 1;
            $error("pcWrite and ifIdEn differ");
        end

    mduClrCause: assert property (@(posedge clk) disable iff (!rstN) mduClr |-> (busy || start))
        else begin
            failCount = failCount + 1;
            $error("mduClr high with the multiply/divide unit idle");
        end

    // Slots are empty right after reset
    firstCycle: assert property (@(posedge clk) $rose(rstN) |-> pcWrite)
        else begin
            failCount = failCount + 1;
            $error("pcWrite low in the first cycle after reset");
        end

endmodule

bind hazardTop hazardTop_checker u_hazardTopChecker (
    .clk     (clk),
    .rstN    (rstN),
    .busy    (busy),
    .start   (start),
    .pcWrite (pcWrite),
    .ifIdEn  (ifIdEn),
    .idExClr (idExClr),
    .mduClr  (mduClr)
);

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    --top-module hazardTb -f verilog.f -o hazardSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

simOutput=$(./obj_dir/hazardSim +verilator+error+limit+1000)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOutput" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1

// File: stallController.sv
`timescale 1ns/1ps
`default_nettype none

module stallController import hazardPkg::*; (
    input  logic [regNumW-1:0] useRs,
    input  logic [regNumW-1:0] useRt,
    input  logic [timeW-1:0]   tuseRs,
    input  logic [timeW-1:0]   tuseRt,
    input  logic               mdAccess,
    input  logic               mdStart,
    input  logic [regNumW-1:0] newRegE,
    input  logic [timeW-1:0]   tnewE,
    input  logic [regNumW-1:0] newRegM,
    input  logic [timeW-1:0]   tnewM,
    input  logic               busy,
    input  logic               start,
    output logic               stall,
    output logic               pcWrite,
    output logic               ifIdEn,
    output logic               idExClr,
    output logic               mduClr
);

    logic rsHazardE;
    logic rsHazardM;
    logic rtHazardE;
    logic rtHazardM;
    logic mdOccupied;
    logic mdStall;

    // Operand needed before the writer in that slot can forward it
    function automatic logic regHazard(
        input logic [regNumW-1:0] useReg,
        input logic [timeW-1:0]   tuse,
        input logic [regNumW-1:0] newReg,
        input logic [timeW-1:0]   tnew
    );
        return (useReg != '0) && (useReg == newReg) && (tuse < tnew);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Register dependences
    ////////////////////////////////////////////////////////////////////////////

    assign rsHazardE = regHazard(useRs, tuseRs, newRegE, tnewE);
    assign rsHazardM = regHazard(useRs, tuseRs, newRegM, tnewM);
    assign rtHazardE = regHazard(useRt, tuseRt, newRegE, tnewE);
    assign rtHazardM = regHazard(useRt, tuseRt, newRegM, tnewM);

    ////////////////////////////////////////////////////////////////////////////
    // Multiply/divide interlock
    ////////////////////////////////////////////////////////////////////////////

    // Start counts as busy in the cycle the unit launches
    assign mdOccupied = busy | start;
    assign mdStall    = mdAccess & mdOccupied;
    // New op is dropped instead of holding decode
    assign mduClr     = mdStart & mdOccupied;

    assign stall = rsHazardE | rsHazardM | rtHazardE | rtHazardM | mdStall;

    // Freeze fetch and decode, bubble into execute
    assign pcWrite = ~stall;
    assign ifIdEn  = ~stall;
    assign idExClr = stall;

endmodule

`default_nettype wire

// File: useDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module useDecoder import hazardPkg::*; (
    input  logic [31:0]        instrD,
    output logic [regNumW-1:0] useRs,
    output logic [regNumW-1:0] useRt,
    output logic [timeW-1:0]   tuseRs,
    output logic [timeW-1:0]   tuseRt,
    output logic               mdAccess,
    output logic               mdStart
);

    opcodeT             opcode;
    functT              funct;
    logic [regNumW-1:0] rs;
    logic [regNumW-1:0] rt;

    assign opcode = opcodeT'(instrD[opMsb:opLsb]);
    assign funct  = functT'(instrD[functMsb:functLsb]);
    assign rs     = instrD[rsMsb:rsLsb];
    assign rt     = instrD[rtMsb:rtLsb];

    ////////////////////////////////////////////////////////////////////////////
    // Source registers and Tuse
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // Nothing read unless the class says so
        useRs    = '0;
        useRt    = '0;
        tuseRs   = tuseDecode;
        tuseRt   = tuseDecode;
        mdAccess = 1'b0;
        mdStart  = 1'b0;

        case (opcode)
            opRType: begin
                case (funct)
                    functAdd, functSub, functAnd, functOr, functSlt, functSltu: begin
                        useRs  = rs;
                        useRt  = rt;
                        tuseRs = tuseExec;
                        tuseRt = tuseExec;
                    end
                    functMult, functMultu, functDiv, functDivu, functFastdiv: begin
                        useRs   = rs;
                        useRt   = rt;
                        tuseRs  = tuseExec;
                        tuseRt  = tuseExec;
                        mdStart = 1'b1;
                    end
                    functMthi, functMtlo: begin
                        useRs    = rs;
                        tuseRs   = tuseExec;
                        mdAccess = 1'b1;
                    end
                    functMfhi, functMflo: begin
                        mdAccess = 1'b1;
                    end
                    // Target needed before the jump leaves decode
                    functJr: begin
                        useRs  = rs;
                        tuseRs = tuseDecode;
                    end
                    default: begin
                        useRs = '0;
                    end
                endcase
            end

            opOri, opAddi, opAndi, opLw, opLb, opLh: begin
                useRs  = rs;
                tuseRs = tuseExec;
            end

            // Store data is only needed in memory
            opSw, opSb, opSh: begin
                useRs  = rs;
                useRt  = rt;
                tuseRs = tuseExec;
                tuseRt = tuseMem;
            end

            // Compared in decode
            opBeq, opBne: begin
                useRs  = rs;
                useRt  = rt;
                tuseRs = tuseDecode;
                tuseRt = tuseDecode;
            end

            // lui, j and jal read no register
            opLui, opJ, opJal: begin
                useRs = '0;
            end

            default: begin
                useRs = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog.f
hazardPkg.sv
useDecoder.sv
writerTracker.sv
stallController.sv
hazardTop.sv
hazardTop_checker.sv
hazardMonitor.sv
hazardTb.sv

// File: writerTracker.sv
`timescale 1ns/1ps
`default_nettype none

module writerTracker import hazardPkg::*; (
    input  logic               clk,
    input  logic               rstN,
    input  logic [31:0]        instrD,
    input  logic               stall,
    output logic [regNumW-1:0] newRegE,
    output logic [timeW-1:0]   tnewE,
    output logic [regNumW-1:0] newRegM,
    output logic [timeW-1:0]   tnewM
);

    opcodeT             opcode;
    functT              funct;
    logic [regNumW-1:0] rt;
    logic [regNumW-1:0] rd;
    logic [regNumW-1:0] destD;
    logic [timeW-1:0]   tnewRaw;
    logic [timeW-1:0]   tnewD;
    logic [timeW-1:0]   tnewAged;

    assign opcode = opcodeT'(instrD[opMsb:opLsb]);
    assign funct  = functT'(instrD[functMsb:functLsb]);
    assign rt     = instrD[rtMsb:rtLsb];
    assign rd     = instrD[rdMsb:rdLsb];

    ////////////////////////////////////////////////////////////////////////////
    // Destination of the decode instruction
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        destD   = '0;
        tnewRaw = tnewLink;

        case (opcode)
            opRType: begin
                case (funct)
                    functAdd, functSub, functAnd, functOr, functSlt, functSltu,
                    functMfhi, functMflo: begin
                        destD   = rd;
                        tnewRaw = tnewAlu;
                    end
                    default: begin
                        destD = '0;
                    end
                endcase
            end

            opOri, opAddi, opAndi, opLui: begin
                destD   = rt;
                tnewRaw = tnewAlu;
            end

            opLw, opLb, opLh: begin
                destD   = rt;
                tnewRaw = tnewLoad;
            end

            // Link address is ready as soon as the jump is decoded
            opJal: begin
                destD   = linkReg;
                tnewRaw = tnewLink;
            end

            default: begin
                destD = '0;
            end
        endcase
    end

    // A write to r0 is no write
    assign tnewD = (destD == '0) ? '0 : tnewRaw;

    // One stage closer to the result, never below zero
    assign tnewAged = (tnewE == '0) ? '0 : tnewE - 1'b1;

    ////////////////////////////////////////////////////////////////////////////
    // Execute and memory slots
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            newRegE <= '0;
            tnewE   <= '0;
            newRegM <= '0;
            tnewM   <= '0;
        end else begin
            if (stall) begin
                // Bubble into execute
                newRegE <= '0;
                tnewE   <= '0;
            end else begin
                newRegE <= destD;
                tnewE   <= tnewD;
            end
            newRegM <= newRegE;
            tnewM   <= tnewAged;
        end
    end

endmodule

`default_nettype wire
